/* hdl/pyonpyon_pkg.sv */
`default_nettype none

package pyonpyon_pkg;

  // --------------------
  // widths
  // --------------------
  localparam int digit_w   = 4;  // one bcd digit
  localparam int seg_w     = 7;  // one active-low seven-segment code
  localparam int box_count = 33; // boxes per race
  localparam int preview_w = 8;  // upcoming boxes on box_leds
  localparam int div_w     = 8;  // rate divider width
  localparam int speed_w   = 2;  // cpu speed selector

  // --------------------
  // race setup
  // --------------------
  // 0 = left box, 1 = right box, bit 0 is the first box
  localparam logic [box_count-1:0] box_pattern =
    33'b0_1101_0001_0101_1101_1001_0110_1000_1001;

  localparam logic [digit_w-1:0] start_tens = digit_w'(3); // score starts at 33
  localparam logic [digit_w-1:0] start_ones = digit_w'(3);
  localparam logic [digit_w-1:0] digit_nine = digit_w'(9); // top bcd value

  // --------------------
  // rate reloads
  // --------------------
  // simulation-scale counts, tick period is reload + 1 cycles
  localparam logic [div_w-1:0] cpu_reload_easy    = div_w'(59);
  localparam logic [div_w-1:0] cpu_reload_medium  = div_w'(44);
  localparam logic [div_w-1:0] cpu_reload_hard    = div_w'(29);
  localparam logic [div_w-1:0] cpu_reload_extreme = div_w'(17);

  localparam logic [div_w-1:0] timer_reload = div_w'(89); // one timer count per 90 cycles

  // speed selector codes
  localparam logic [speed_w-1:0] speed_easy    = 2'b00;
  localparam logic [speed_w-1:0] speed_medium  = 2'b01;
  localparam logic [speed_w-1:0] speed_hard    = 2'b10;
  localparam logic [speed_w-1:0] speed_extreme = 2'b11;

endpackage

`default_nettype wire

/* hdl/race_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface race_if
  import pyonpyon_pkg::*;
();

  logic [digit_w-1:0] player_tens;  // player score, counts down
  logic [digit_w-1:0] player_ones;
  logic [digit_w-1:0] cpu_tens;     // cpu score, counts down
  logic [digit_w-1:0] cpu_ones;
  logic [digit_w-1:0] time_tens;    // game timer, counts up
  logic [digit_w-1:0] time_ones;
  logic               player_done;  // player reached 00
  logic               game_over;    // either racer reached 00

  modport execute (
    output player_tens, player_ones, cpu_tens, cpu_ones,
    output time_tens, time_ones, player_done, game_over
  );

  modport result (
    input player_tens, player_ones, cpu_tens, cpu_ones,
    input time_tens, time_ones, player_done, game_over
  );

endinterface

`default_nettype wire

/* hdl/move_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module move_decode
  import pyonpyon_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 new_game,   // reload the box sequence
  input  logic                 run,        // race running
  input  logic                 game_over,  // race finished, moves ignored
  input  logic                 left_key,
  input  logic                 right_key,
  output logic                 step,       // one-cycle strobe per correct move
  output logic                 box_cue,    // level of the current box
  output logic                 cue_left,
  output logic                 cue_right,
  output logic [preview_w-1:0] box_leds    // upcoming boxes
);

  logic [box_count-1:0] box_reg;     // remaining boxes, bit 0 is current
  logic                 match;       // switch for current box is up
  logic                 match_prev;  // match as seen on last edge

  // --------------------
  // switch match
  // --------------------
  assign box_cue   = box_reg[0];
  assign cue_right = box_reg[0];   // right box lights the right cue
  assign cue_left  = ~box_reg[0];
  assign box_leds  = box_reg[preview_w-1:0];

  assign match = box_reg[0] ? right_key : left_key;

  // rising edge of match only, a held switch gives one step
  assign step = match & ~match_prev & run & ~game_over;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      match_prev <= 1'b0;
    end else begin
      match_prev <= match;  // tracked every cycle
    end
  end

  // --------------------
  // box shift register
  // --------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      box_reg <= box_pattern;
    end else if (new_game) begin
      box_reg <= box_pattern;  // fresh race
    end else if (step) begin
      box_reg <= {1'b0, box_reg[box_count-1:1]};  // next box moves to bit 0
    end
  end

endmodule

`default_nettype wire

/* hdl/race_execute.sv */
`timescale 1ns/1ns
`default_nettype none

module race_execute
  import pyonpyon_pkg::*;
(
  input  logic               clk,
  input  logic               reset,
  input  logic               new_game,   // reload scores, timer and dividers
  input  logic               run,        // race running
  input  logic [speed_w-1:0] speed,      // cpu rate select
  input  logic               step,       // correct player move
  output logic               game_over,  // either racer finished
  race_if.execute            rs
);

  logic [digit_w-1:0] player_tens, player_ones;
  logic [digit_w-1:0] cpu_tens, cpu_ones;
  logic [digit_w-1:0] time_tens, time_ones;
  logic [2*digit_w-1:0] player_nxt, cpu_nxt, time_nxt;
  logic player_done, cpu_done;

  logic               count_en;      // race clock gate
  logic [div_w-1:0]   speed_reload;  // reload for the selected speed
  logic [div_w-1:0]   cpu_div;
  logic [div_w-1:0]   cpu_cur;       // divider value seen this cycle
  logic               div_fresh;     // divider not yet started, follows speed
  logic               cpu_tick;
  logic [div_w-1:0]   tmr_div;
  logic               tmr_tick;

  // bcd countdown that stops at 00
  function automatic logic [2*digit_w-1:0] bcd_down(input logic [digit_w-1:0] tens,
                                                    input logic [digit_w-1:0] ones);
    if (ones != '0) begin
      bcd_down = {tens, ones - 1'b1};
    end else if (tens != '0) begin
      bcd_down = {tens - 1'b1, digit_nine};  // borrow, x0 -> (x-1)9
    end else begin
      bcd_down = '0;
    end
  endfunction

  // bcd count up, 99 wraps to 00
  function automatic logic [2*digit_w-1:0] bcd_up(input logic [digit_w-1:0] tens,
                                                  input logic [digit_w-1:0] ones);
    if (ones != digit_nine) begin
      bcd_up = {tens, ones + 1'b1};
    end else if (tens != digit_nine) begin
      bcd_up = {tens + 1'b1, {digit_w{1'b0}}};
    end else begin
      bcd_up = '0;
    end
  endfunction

  function automatic logic [div_w-1:0] reload_of(input logic [speed_w-1:0] sel);
    case (sel)
      speed_easy:   reload_of = cpu_reload_easy;
      speed_medium: reload_of = cpu_reload_medium;
      speed_hard:   reload_of = cpu_reload_hard;
      default:      reload_of = cpu_reload_extreme;
    endcase
  endfunction

  assign game_over = player_done | cpu_done;
  assign count_en  = run & ~game_over;

  // --------------------
  // rate dividers
  // --------------------
  assign speed_reload = reload_of(speed);
  assign cpu_cur      = div_fresh ? speed_reload : cpu_div;
  assign cpu_tick     = count_en & (cpu_cur == '0);
  assign tmr_tick     = count_en & (tmr_div == '0);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cpu_div   <= '0;
      div_fresh <= 1'b1;
      tmr_div   <= timer_reload;
    end else if (new_game) begin
      cpu_div   <= '0;
      div_fresh <= 1'b1;  // restart from whatever speed is picked
      tmr_div   <= timer_reload;
    end else if (count_en) begin
      div_fresh <= 1'b0;
      cpu_div   <= cpu_tick ? speed_reload : cpu_cur - 1'b1;  // reload uses speed right now
      tmr_div   <= tmr_tick ? timer_reload : tmr_div - 1'b1;
    end
  end

  // --------------------
  // scores and timer
  // --------------------
  always_comb begin
    player_nxt = step ? bcd_down(player_tens, player_ones) : {player_tens, player_ones};
    cpu_nxt    = cpu_tick ? bcd_down(cpu_tens, cpu_ones) : {cpu_tens, cpu_ones};
    time_nxt   = tmr_tick ? bcd_up(time_tens, time_ones) : {time_tens, time_ones};
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      {player_tens, player_ones} <= {start_tens, start_ones};
      {cpu_tens, cpu_ones}       <= {start_tens, start_ones};
      {time_tens, time_ones}     <= '0;
      player_done                <= 1'b0;
      cpu_done                   <= 1'b0;
    end else if (new_game) begin
      {player_tens, player_ones} <= {start_tens, start_ones};
      {cpu_tens, cpu_ones}       <= {start_tens, start_ones};
      {time_tens, time_ones}     <= '0;
      player_done                <= 1'b0;
      cpu_done                   <= 1'b0;
    end else if (!game_over) begin  // everything freezes at the finish
      {player_tens, player_ones} <= player_nxt;
      {cpu_tens, cpu_ones}       <= cpu_nxt;
      {time_tens, time_ones}     <= time_nxt;
      player_done                <= (player_nxt == '0);  // both can land on one edge
      cpu_done                   <= (cpu_nxt == '0);
    end
  end

  assign rs.player_tens = player_tens;
  assign rs.player_ones = player_ones;
  assign rs.cpu_tens    = cpu_tens;
  assign rs.cpu_ones    = cpu_ones;
  assign rs.time_tens   = time_tens;
  assign rs.time_ones   = time_ones;
  assign rs.player_done = player_done;
  assign rs.game_over   = game_over;

endmodule

`default_nettype wire

/* hdl/score_result.sv */
`timescale 1ns/1ns
`default_nettype none

module score_result
  import pyonpyon_pkg::*;
(
  input  logic             clk,
  input  logic             reset,
  race_if.result           rs,
  output logic [seg_w-1:0] hex0,  // time ones
  output logic [seg_w-1:0] hex1,  // time tens
  output logic [seg_w-1:0] hex2,  // high score ones
  output logic [seg_w-1:0] hex3,  // high score tens
  output logic [seg_w-1:0] hex4,  // cpu ones
  output logic [seg_w-1:0] hex5,  // cpu tens
  output logic [seg_w-1:0] hex6,  // player ones
  output logic [seg_w-1:0] hex7   // player tens
);

  logic                 done_prev;  // player_done on last edge
  logic                 done_rise;
  logic [2*digit_w-1:0] best;       // lowest finishing time, 00 = none yet
  logic [2*digit_w-1:0] finish;     // timer as it froze

  // active-low segments gfedcba
  function automatic logic [seg_w-1:0] seg7(input logic [digit_w-1:0] digit);
    case (digit)
      4'd0:    seg7 = 7'b100_0000;
      4'd1:    seg7 = 7'b111_1001;
      4'd2:    seg7 = 7'b010_0100;
      4'd3:    seg7 = 7'b011_0000;
      4'd4:    seg7 = 7'b001_1001;
      4'd5:    seg7 = 7'b001_0010;
      4'd6:    seg7 = 7'b000_0010;
      4'd7:    seg7 = 7'b111_1000;
      4'd8:    seg7 = 7'b000_0000;
      4'd9:    seg7 = 7'b001_0000;
      default: seg7 = 7'b100_0000;  // not bcd, show 0
    endcase
  endfunction

  // --------------------
  // high score
  // --------------------
  assign finish    = {rs.time_tens, rs.time_ones};  // bcd order compares like binary
  assign done_rise = rs.player_done & ~done_prev;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      done_prev <= 1'b0;
      best      <= '0;
    end else begin
      done_prev <= rs.player_done;
      if (done_rise && (best == '0 || finish < best)) begin
        best <= finish;  // kept across new games
      end
    end
  end

  // --------------------
  // display
  // --------------------
  assign hex0 = seg7(rs.time_ones);
  assign hex1 = seg7(rs.time_tens);
  assign hex2 = seg7(best[digit_w-1:0]);
  assign hex3 = seg7(best[2*digit_w-1:digit_w]);
  assign hex4 = seg7(rs.cpu_ones);
  assign hex5 = seg7(rs.cpu_tens);
  assign hex6 = seg7(rs.player_ones);
  assign hex7 = seg7(rs.player_tens);

endmodule

`default_nettype wire

/* hdl/pyonpyon_top.sv */
`timescale 1ns/1ns
`default_nettype none

module pyonpyon_top
  import pyonpyon_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 new_game,
  input  logic                 run,
  input  logic [speed_w-1:0]   speed,
  input  logic                 left_key,
  input  logic                 right_key,
  output logic [preview_w-1:0] box_leds,
  output logic                 cue_left,
  output logic                 cue_right,
  output logic [seg_w-1:0]     hex0, hex1, hex2, hex3,
  output logic [seg_w-1:0]     hex4, hex5, hex6, hex7
);

  logic step;       // correct move strobe
  logic game_over;  // race finished

  race_if rs ();  // race state, execute to result

  move_decode i_decode (
    .clk, .reset, .new_game, .run,
    .game_over,
    .left_key, .right_key,
    .step,
    .box_cue   (),  // same level as cue_right
    .cue_left, .cue_right, .box_leds
  );

  race_execute i_execute (
    .clk, .reset, .new_game, .run, .speed,
    .step,
    .game_over,
    .rs        (rs.execute)
  );

  score_result i_result (
    .clk, .reset,
    .rs        (rs.result),
    .hex0, .hex1, .hex2, .hex3,
    .hex4, .hex5, .hex6, .hex7
  );

endmodule

`default_nettype wire

/* verif/pyonpyon_tb_tasks.svh */
`ifndef PYONPYON_TB_TASKS_SVH
`define PYONPYON_TB_TASKS_SVH

// --------------------
// check
// --------------------
task automatic check_value(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
  if (actual !== expected) begin
    errors++;  // counted per case by the caller
    $display("Fail %s: got %h, expected %h", name, actual, expected);
  end
endtask

// --------------------
// display helpers
// --------------------
// active-low, bit 6 is segment g
function automatic logic [seg_w-1:0] seg_of(input int digit);
  case (digit)
    0:       seg_of = 7'h40;
    1:       seg_of = 7'h79;
    2:       seg_of = 7'h24;
    3:       seg_of = 7'h30;
    4:       seg_of = 7'h19;
    5:       seg_of = 7'h12;
    6:       seg_of = 7'h02;
    7:       seg_of = 7'h78;
    8:       seg_of = 7'h00;
    9:       seg_of = 7'h10;
    default: seg_of = 7'h40;  // out of range shows 0
  endcase
endfunction

function automatic int tens_digit(input int value);
  tens_digit = (value / 10) % 10;
endfunction

function automatic int ones_digit(input int value);
  ones_digit = value % 10;
endfunction

// box level at a race position, 0 past the last box
function automatic logic box_bit(input int index);
  if (index < box_count) begin
    box_bit = box_pattern[index];
  end else begin
    box_bit = 1'b0;
  end
endfunction

`endif

/* verif/pyonpyon_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module pyonpyon_tb
  import pyonpyon_pkg::*;
();

  logic               clk = 1'b0;
  logic               reset;
  logic               new_game;
  logic               run;
  logic [speed_w-1:0] speed;
  logic               left_key;
  logic               right_key;
  logic [preview_w-1:0] box_leds;
  logic               cue_left;
  logic               cue_right;
  logic [seg_w-1:0]   hex0, hex1, hex2, hex3, hex4, hex5, hex6, hex7;

  int q_kind[$];   // one entry per case line
  int q_speed[$];
  int q_moves[$];
  int q_wrong[$];
  int q_len[$];
  int q_exp[$];    // player score expected at case end

  int          errors      = 0;
  int          cycles      = 0;
  int          cycle_limit = 200;  // grows with every case read
  logic [31:0] lfsr        = 32'h8afd_fd16;

  // reference model state, integers rather than bcd
  int   m_player = 33;
  int   m_cpu    = 33;
  int   m_time   = 0;
  int   m_box    = 0;    // index of the current box
  int   m_runs   = 0;    // running cycles since the game started
  int   m_best   = 0;
  logic m_pdone  = 1'b0;
  logic m_cdone  = 1'b0;
  logic m_pdone_prev = 1'b0;
  logic m_match_prev = 1'b0;

  `include "pyonpyon_tb_tasks.svh"

  pyonpyon_top i_dut (
    .clk, .reset, .new_game, .run, .speed, .left_key, .right_key,
    .box_leds, .cue_left, .cue_right,
    .hex0, .hex1, .hex2, .hex3, .hex4, .hex5, .hex6, .hex7
  );

  always #50 clk = ~clk;  // 100 ns period

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic int cpu_period(input logic [speed_w-1:0] sel);
    case (sel)
      speed_easy:   cpu_period = cpu_reload_easy + 1;
      speed_medium: cpu_period = cpu_reload_medium + 1;
      speed_hard:   cpu_period = cpu_reload_hard + 1;
      default:      cpu_period = cpu_reload_extreme + 1;
    endcase
  endfunction

  // --------------------
  // reference model
  // --------------------
  always @(posedge clk or posedge reset) begin : ref_model
    logic over;
    logic running;
    logic match_now;
    logic step_now;
    if (reset) begin
      m_player = 33;
      m_cpu    = 33;
      m_time   = 0;
      m_box    = 0;
      m_runs   = 0;
      m_best   = 0;  // only reset clears the high score
      m_pdone  = 1'b0;
      m_cdone  = 1'b0;
      m_pdone_prev = 1'b0;
      m_match_prev = 1'b0;
    end else begin
      over      = m_pdone | m_cdone;
      running   = run & ~over;
      match_now = box_bit(m_box) ? right_key : left_key;
      step_now  = match_now & ~m_match_prev & running;  // rising match only
      if (m_pdone && !m_pdone_prev && (m_best == 0 || m_time < m_best)) begin
        m_best = m_time;  // time already frozen here
      end
      m_pdone_prev = m_pdone;
      m_match_prev = match_now;
      if (new_game) begin
        m_player = 33;
        m_cpu    = 33;
        m_time   = 0;
        m_box    = 0;
        m_runs   = 0;
        m_pdone  = 1'b0;
        m_cdone  = 1'b0;
      end else if (running) begin
        m_runs++;
        if (step_now) begin
          m_box++;
          if (m_player > 0) m_player--;
        end
        if (m_runs % cpu_period(speed) == 0 && m_cpu > 0) m_cpu--;
        if (m_runs % (timer_reload + 1) == 0) m_time = (m_time + 1) % 100;
        m_pdone = (m_player == 0);
        m_cdone = (m_cpu == 0);
      end
    end
  end

  // --------------------
  // stimulus
  // --------------------
  task automatic check_outputs();
    logic [preview_w-1:0] leds;
    int i;
    for (i = 0; i < preview_w; i++) leds[i] = box_bit(m_box + i);
    check_value("box_leds", box_leds, leds);
    check_value("cue_right", cue_right, box_bit(m_box));
    check_value("cue_left", cue_left, !box_bit(m_box));
    check_value("hex0", hex0, seg_of(ones_digit(m_time)));
    check_value("hex1", hex1, seg_of(tens_digit(m_time)));
    check_value("hex2", hex2, seg_of(ones_digit(m_best)));
    check_value("hex3", hex3, seg_of(tens_digit(m_best)));
    check_value("hex4", hex4, seg_of(ones_digit(m_cpu)));
    check_value("hex5", hex5, seg_of(tens_digit(m_cpu)));
    check_value("hex6", hex6, seg_of(ones_digit(m_player)));
    check_value("hex7", hex7, seg_of(tens_digit(m_player)));
  endtask

  // one clock, then inputs may change 5 ns after the edge
  task automatic next_cycle();
    @(posedge clk);
    #5;
    check_outputs();
  endtask

  task automatic wrong_attempt();
    if (box_bit(m_box)) left_key = 1'b1;  // opposite of the current box
    else right_key = 1'b1;
    repeat (2) next_cycle();
    left_key  = 1'b0;
    right_key = 1'b0;
    next_cycle();
  endtask

  task automatic press_move(input logic held);
    int gap;
    gap = 0;
    if (box_bit(m_box)) right_key = 1'b1;
    else left_key = 1'b1;
    repeat (held ? 3 : 1) next_cycle();  // held switch still one step
    left_key  = 1'b0;
    right_key = 1'b0;
    repeat (2) begin
      lfsr = lfsr_step(lfsr);
      gap  = (gap << 1) | lfsr[0];
    end
    repeat (gap + 1) next_cycle();  // 1 to 4 idle cycles
  endtask

  task automatic run_case(input int kind, input int spd, input int moves,
                          input int wrong, input int len);
    int i;
    case (kind)
      0: begin  // reset in the middle of the run
        reset = 1'b1;
        repeat (len) next_cycle();
        reset = 1'b0;
        next_cycle();
      end
      1, 2: begin  // new game, run high
        speed    = speed_w'(spd);
        new_game = 1'b1;
        run      = 1'b0;
        next_cycle();
        new_game = 1'b0;
        run      = 1'b1;
        if (kind == 2) repeat (len) next_cycle();  // idle first, slower finish
        if (wrong != 0) wrong_attempt();
        for (i = 0; i < moves; i++) press_move(i == 1);  // boxes 1 and 2 share a side
        if (kind == 1) begin
          repeat (len) next_cycle();
          if (m_pdone || m_cdone) press_move(1'b1);  // race over, score and timer hold
        end
        run = 1'b0;
        next_cycle();
      end
      default: begin  // run low, nothing may move
        run = 1'b0;
        if (wrong != 0) wrong_attempt();
        for (i = 0; i < moves; i++) press_move(1'b0);
        repeat (len) next_cycle();
      end
    endcase
  endtask

  task automatic read_cases();
    logic [8*128-1:0] line;
    int fd;
    int code;
    int kind, spd, moves, wrong, len, exp_score;
    fd = $fopen("verif/pyonpyon_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open the case file verif/pyonpyon_cases.txt");
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code > 0 &&
            $sscanf(line, "%d %d %d %d %d %d", kind, spd, moves, wrong, len, exp_score) == 6) begin
          q_kind.push_back(kind);
          q_speed.push_back(spd);
          q_moves.push_back(moves);
          q_wrong.push_back(wrong);
          q_len.push_back(len);
          q_exp.push_back(exp_score);
          cycle_limit += len + 4 * moves;
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin : main
    int i;
    int errors_before;
    int passed;
    int failed;
    reset     = 1'b1;
    new_game  = 1'b0;
    run       = 1'b0;
    speed     = '0;
    left_key  = 1'b0;
    right_key = 1'b0;
    passed    = 0;
    failed    = 0;
    read_cases();
    repeat (10) next_cycle();
    reset = 1'b0;
    for (i = 0; i < q_kind.size(); i++) begin
      errors_before = errors;
      run_case(q_kind[i], q_speed[i], q_moves[i], q_wrong[i], q_len[i]);
      check_value("player score", {hex7, hex6},
                  {seg_of(tens_digit(q_exp[i])), seg_of(ones_digit(q_exp[i]))});
      if (errors == errors_before) begin
        passed++;
        $display("case %0d kind %0d speed %0d moves %0d: pass", i, q_kind[i], q_speed[i],
                 q_moves[i]);
      end else begin
        failed++;
        $display("case %0d kind %0d speed %0d moves %0d: fail, %0d mismatches", i, q_kind[i],
                 q_speed[i], q_moves[i], errors - errors_before);
      end
    end
    $display("cases passed %0d, failed %0d", passed, failed);
    if (errors == 0 && q_kind.size() > 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verif/pyonpyon_cases.txt */
# kind speed moves wrong run_len player_score_at_end
# kind 0 reset, 1 moves then run, 2 run then moves, 3 run low
0 0 0 0 3 33
1 3 4 1 60 29
1 0 0 0 130 33
1 1 0 0 100 33
1 2 2 1 70 31
3 2 3 1 40 31
2 0 33 0 200 0
2 0 33 0 400 0
2 0 33 0 40 0
1 3 2 0 620 31
0 0 0 0 2 33

/* pyonpyon.f */
+incdir+verif
hdl/pyonpyon_pkg.sv
hdl/race_if.sv
hdl/move_decode.sv
hdl/race_execute.sv
hdl/score_result.sv
hdl/pyonpyon_top.sv
verif/pyonpyon_tb.sv
